/* source/axi_lite_pkg.sv */
package axi_lite_pkg;

  //////////////////////////////////////////////////
  // AXI4-Lite port geometry
  //////////////////////////////////////////////////

  // Data bus, one 32-bit word per register
  localparam int axi_data_width = 32;
  // Byte address, 11 bits covers the whole register window
  localparam int axi_addr_width = 11;
  // One write strobe per byte lane
  localparam int axi_strb_width = axi_data_width / 8;

  // Response field of the B and R channels
  typedef logic [1:0] axi_resp_t;

  // Only OKAY is ever returned
  localparam axi_resp_t resp_okay = 2'b00;

endpackage

/* source/apg_reg_pkg.sv */
package apg_reg_pkg;

  //////////////////////////////////////////////////
  // Register map of the pattern generator
  //////////////////////////////////////////////////

  // Number of word registers in the window
  localparam int reg_count = 13;

  // Word index, byte address shifted down by two
  typedef logic [3:0] reg_addr_t;

  // Register indices
  localparam reg_addr_t addr_run              = 4'd0;
  localparam reg_addr_t addr_write_channel    = 4'd1;
  localparam reg_addr_t addr_read_channel     = 4'd2;
  localparam reg_addr_t addr_sample_count     = 4'd3;
  localparam reg_addr_t addr_n_samples        = 4'd4;
  localparam reg_addr_t addr_control          = 4'd5;
  localparam reg_addr_t addr_write_buffer_len = 4'd6;
  localparam reg_addr_t addr_next_read_sample = 4'd7;
  localparam reg_addr_t addr_wave_ptr         = 4'd8;
  localparam reg_addr_t addr_status           = 4'd9;
  localparam reg_addr_t addr_clear            = 4'd10;
  localparam reg_addr_t addr_dbg_error        = 4'd11;
  localparam reg_addr_t addr_write_defaults   = 4'd12;

  // Control register, continuous loop
  localparam int ctrl_loop = 0;

  // Status register bits
  localparam int stat_running  = 0;
  localparam int stat_done     = 1;
  localparam int stat_overflow = 2;

endpackage

/* source/axi4lite_slave.sv */
`timescale 1ns/100ps

module axi4lite_slave import axi_lite_pkg::*, apg_reg_pkg::*; (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic [axi_addr_width-1:0] S_AXI_AWADDR,
  input  logic [2:0]                S_AXI_AWPROT,
  input  logic                      S_AXI_AWVALID,
  output logic                      S_AXI_AWREADY,
  input  logic [axi_data_width-1:0] S_AXI_WDATA,
  input  logic [axi_strb_width-1:0] S_AXI_WSTRB,
  input  logic                      S_AXI_WVALID,
  output logic                      S_AXI_WREADY,
  output axi_resp_t                 S_AXI_BRESP,
  output logic                      S_AXI_BVALID,
  input  logic                      S_AXI_BREADY,
  input  logic [axi_addr_width-1:0] S_AXI_ARADDR,
  input  logic [2:0]                S_AXI_ARPROT,
  input  logic                      S_AXI_ARVALID,
  output logic                      S_AXI_ARREADY,
  output logic [axi_data_width-1:0] S_AXI_RDATA,
  output axi_resp_t                 S_AXI_RRESP,
  output logic                      S_AXI_RVALID,
  input  logic                      S_AXI_RREADY,
  // Register side
  output logic [axi_data_width-1:0] reg_wdata,
  output logic [axi_strb_width-1:0] reg_wr_strb [reg_count],
  output logic [reg_count-1:0]      reg_rd_stb,
  input  logic [axi_data_width-1:0] reg_rdata [reg_count]
);

  // Word index width, byte offset dropped
  localparam int word_w = axi_addr_width - 2;

  logic [word_w-1:0]         aw_word;
  logic [word_w-1:0]         ar_word;
  logic                      aw_ready;
  logic                      ar_ready;
  logic                      b_valid;
  logic                      r_valid;
  logic                      wr_hs;
  logic                      ar_hs;
  logic                      wr_pulse;
  logic                      rd_pulse;
  reg_addr_t                 wr_idx;
  reg_addr_t                 rd_idx;
  logic [axi_strb_width-1:0] wstrb_q;

  assign aw_word = S_AXI_AWADDR[axi_addr_width-1:2];
  assign ar_word = S_AXI_ARADDR[axi_addr_width-1:2];

  // Handshake cycles
  assign wr_hs = aw_ready & S_AXI_AWVALID & S_AXI_WVALID;
  assign ar_hs = ar_ready & S_AXI_ARVALID;

  //////////////////////////////////////////////////
  // Write channel
  //////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      aw_ready <= 1'b0;
      b_valid  <= 1'b0;
      wr_pulse <= 1'b0;
    end else begin
      // Address and data taken together, one write in flight
      aw_ready <= ~aw_ready & S_AXI_AWVALID & S_AXI_WVALID & ~b_valid;
      // Strobe only for words inside the map
      wr_pulse <= wr_hs & (aw_word < word_w'(reg_count));
      if (wr_hs) begin
        b_valid <= 1'b1;
      end else if (S_AXI_BREADY) begin
        b_valid <= 1'b0;
      end
    end
  end

  // Payload of the accepted write
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_hs) begin
      wr_idx    <= reg_addr_t'(aw_word);
      wstrb_q   <= S_AXI_WSTRB;
      reg_wdata <= S_AXI_WDATA;
    end
  end

  //////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
      rd_pulse <= 1'b0;
    end else begin
      ar_ready <= ~ar_ready & S_AXI_ARVALID & ~r_valid;
      rd_pulse <= ar_hs & (ar_word < word_w'(reg_count));
      if (ar_hs) begin
        r_valid <= 1'b1;
      end else if (S_AXI_RREADY) begin
        r_valid <= 1'b0;
      end
    end
  end

  // Data latched in the handshake cycle, before the read strobe
  always_ff @(posedge S_AXI_ACLK) begin
    if (ar_hs) begin
      rd_idx      <= reg_addr_t'(ar_word);
      S_AXI_RDATA <= (ar_word < word_w'(reg_count)) ? reg_rdata[reg_addr_t'(ar_word)] : '0;
    end
  end

  // One-hot register strobes
  always_comb begin
    for (int i = 0; i < reg_count; i++) begin
      reg_wr_strb[i] = (wr_pulse && wr_idx == i) ? wstrb_q : '0;
      reg_rd_stb[i]  = rd_pulse && rd_idx == i;
    end
  end

  assign S_AXI_AWREADY = aw_ready;
  assign S_AXI_WREADY  = aw_ready;
  assign S_AXI_BVALID  = b_valid;
  assign S_AXI_BRESP   = resp_okay;
  assign S_AXI_ARREADY = ar_ready;
  assign S_AXI_RVALID  = r_valid;
  assign S_AXI_RRESP   = resp_okay;

endmodule

/* source/apg_reg_bank.sv */
`timescale 1ns/100ps

module apg_reg_bank import axi_lite_pkg::*, apg_reg_pkg::*; #(
  parameter int num_sig  = 14,
  parameter int num_samp = 128
) (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic [axi_data_width-1:0] reg_wdata,
  input  logic [axi_strb_width-1:0] reg_wr_strb [reg_count],
  input  logic [reg_count-1:0]      reg_rd_stb,
  output logic [axi_data_width-1:0] reg_rdata [reg_count],
  // Sources of the read-only registers
  input  logic [$clog2(num_samp):0]   pattern_len,
  input  logic [num_sig-1:0]          capture_data,
  input  logic [$clog2(num_samp):0]   capture_len,
  input  logic [$clog2(num_samp):0]   capture_rd_ptr,
  input  logic [31:0]                 sample_count,
  input  logic [$clog2(num_samp)-1:0] wave_ptr,
  input  logic [2:0]                  status,
  input  logic [31:0]                 dbg_error,
  // Strobes and levels to the datapath
  output logic                      run_stb,
  output logic                      clear_stb,
  output logic                      pattern_push,
  output logic [num_sig-1:0]        pattern_data,
  output logic                      capture_pop,
  output logic [31:0]               n_samples,
  output logic [7:0]                control,
  output logic [num_sig-1:0]        write_defaults
);

  // Full-word write to one register
  function automatic logic wr_full(input reg_addr_t idx);
    return reg_wr_strb[idx] == '1;
  endfunction

  //////////////////////////////////////////////////
  // Writable registers and strobes
  //////////////////////////////////////////////////

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      run_stb        <= 1'b0;
      clear_stb      <= 1'b0;
      pattern_push   <= 1'b0;
      n_samples      <= '0;
      control        <= '0;
      write_defaults <= '0;
    end else begin
      // Any value written gives a one-cycle pulse
      run_stb      <= wr_full(addr_run);
      clear_stb    <= wr_full(addr_clear);
      pattern_push <= wr_full(addr_write_channel);
      if (wr_full(addr_n_samples)) begin
        n_samples <= reg_wdata[31:0];
      end
      if (wr_full(addr_control)) begin
        control <= reg_wdata[7:0];
      end
      if (wr_full(addr_write_defaults)) begin
        write_defaults <= reg_wdata[num_sig-1:0];
      end
    end
  end

  // Last sample written, valid together with the push pulse
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      pattern_data <= '0;
    end else if (wr_full(addr_write_channel)) begin
      pattern_data <= reg_wdata[num_sig-1:0];
    end
  end

  // Each read of read_channel advances the capture buffer
  assign capture_pop = reg_rd_stb[addr_read_channel];

  //////////////////////////////////////////////////
  // Read multiplexer, all sources zero-extended
  //////////////////////////////////////////////////

  always_comb begin
    reg_rdata[addr_run]              = axi_data_width'(run_stb);
    reg_rdata[addr_write_channel]    = axi_data_width'(pattern_data);
    reg_rdata[addr_read_channel]     = axi_data_width'(capture_data);
    reg_rdata[addr_sample_count]     = axi_data_width'(sample_count);
    reg_rdata[addr_n_samples]        = axi_data_width'(n_samples);
    reg_rdata[addr_control]          = axi_data_width'(control);
    reg_rdata[addr_write_buffer_len] = axi_data_width'(pattern_len);
    reg_rdata[addr_next_read_sample] = axi_data_width'(capture_rd_ptr);
    reg_rdata[addr_wave_ptr]         = axi_data_width'(wave_ptr);
    reg_rdata[addr_status]           = axi_data_width'(status);
    reg_rdata[addr_clear]            = axi_data_width'(clear_stb);
    reg_rdata[addr_dbg_error]        = axi_data_width'(dbg_error);
    reg_rdata[addr_write_defaults]   = axi_data_width'(write_defaults);
    // Reads past the captured entries return zero
    if (capture_rd_ptr >= capture_len) begin
      reg_rdata[addr_read_channel] = '0;
    end
  end

endmodule

/* source/sample_buffer.sv */
`timescale 1ns/100ps

module sample_buffer #(
  parameter int num_sig  = 14,
  parameter int num_samp = 128
) (
  input  logic                        S_AXI_ACLK,
  input  logic                        S_AXI_ARESETN,
  input  logic                        clear,
  input  logic                        push,
  input  logic [num_sig-1:0]          push_data,
  input  logic                        pop,
  input  logic [$clog2(num_samp)-1:0] rd_addr,
  output logic [num_sig-1:0]          rd_data,
  output logic [$clog2(num_samp):0]   count,
  output logic [$clog2(num_samp):0]   rd_ptr,
  output logic                        full
);

  localparam int ptr_w = $clog2(num_samp);

  logic [num_sig-1:0] mem [num_samp];
  logic [ptr_w-1:0]   wr_ptr;
  logic               wr_en;

  // Pushes into a full buffer are dropped
  assign full  = count == (ptr_w + 1)'(num_samp);
  assign wr_en = push & ~full;

  // Pointers and fill level
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN || clear) begin
      wr_ptr <= '0;
      count  <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        count  <= count + 1'b1;
      end
      // Reader never passes the written entries
      if (pop && rd_ptr < count) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage and registered read port
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

/* source/pattern_sequencer.sv */
`timescale 1ns/100ps

module pattern_sequencer import apg_reg_pkg::*; #(
  parameter int num_sig  = 14,
  parameter int num_samp = 128
) (
  input  logic                        S_AXI_ACLK,
  input  logic                        S_AXI_ARESETN,
  input  logic                        run_stb,
  input  logic                        clear_stb,
  input  logic [31:0]                 n_samples,
  input  logic [7:0]                  control,
  input  logic [num_sig-1:0]          write_defaults,
  input  logic [$clog2(num_samp):0]   pattern_len,
  input  logic [num_sig-1:0]          rd_data,
  input  logic [num_sig-1:0]          input_signals,
  input  logic                        overflow_event,
  output logic [$clog2(num_samp)-1:0] rd_addr,
  output logic [num_sig-1:0]          output_signals,
  output logic                        cap_push,
  output logic [num_sig-1:0]          cap_data,
  output logic [31:0]                 sample_count,
  output logic [$clog2(num_samp)-1:0] wave_ptr,
  output logic [2:0]                  status,
  output logic [31:0]                 dbg_error
);

  localparam int ptr_w = $clog2(num_samp);
  localparam int cnt_w = ptr_w + 1;

  typedef enum logic [1:0] {st_idle, st_prefetch, st_play} state_t;

  state_t             state;
  logic [ptr_w-1:0]   addr_q;
  logic [cnt_w-1:0]   clamp_len;
  logic [cnt_w-1:0]   len_q;
  logic [cnt_w-1:0]   issued;
  logic               loop_q;
  logic               data_v;
  logic               show_v;
  logic               running;
  logic               done;
  logic               overflow;
  logic [num_sig-1:0] out_q;

  // Step through the pattern, wrapping at the length
  function automatic logic [ptr_w-1:0] next_addr(input logic [ptr_w-1:0] a,
                                                 input logic [cnt_w-1:0] len);
    logic [cnt_w-1:0] nxt;
    nxt = cnt_w'(a) + 1'b1;
    return (nxt >= len) ? '0 : nxt[ptr_w-1:0];
  endfunction

  // Zero or oversize length plays the whole buffer
  assign clamp_len = (n_samples == '0 || n_samples > 32'(pattern_len)) ?
                     pattern_len : n_samples[cnt_w-1:0];

  //////////////////////////////////////////////////
  // Playback FSM
  //////////////////////////////////////////////////

  // Idle keeps address 0 on the buffer so the first read starts with run
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN || clear_stb) begin
      state        <= st_idle;
      addr_q       <= '0;
      len_q        <= '0;
      issued       <= '0;
      loop_q       <= 1'b0;
      data_v       <= 1'b0;
      show_v       <= 1'b0;
      running      <= 1'b0;
      done         <= 1'b0;
      sample_count <= '0;
    end else begin
      // Read data of the last issued address moves to the output
      show_v <= data_v;
      if (show_v) begin
        sample_count <= sample_count + 1'b1;
      end
      case (state)
        st_idle: begin
          // Run with an empty buffer is ignored
          if (run_stb && clamp_len != '0) begin
            state        <= st_prefetch;
            len_q        <= clamp_len;
            loop_q       <= control[ctrl_loop];
            addr_q       <= next_addr('0, clamp_len);
            issued       <= cnt_w'(1);
            data_v       <= 1'b1;
            running      <= 1'b1;
            done         <= 1'b0;
            sample_count <= '0;
          end
        end
        default: begin
          // Keep fetching until the length is issued, forever in loop mode
          if (loop_q || issued < len_q) begin
            addr_q <= next_addr(addr_q, len_q);
            data_v <= 1'b1;
            if (issued < len_q) begin
              issued <= issued + 1'b1;
            end
          end else begin
            data_v <= 1'b0;
          end
          if (state == st_prefetch) begin
            state <= st_play;
          end else if (!data_v) begin
            // Last sample on the output now
            state   <= st_idle;
            addr_q  <= '0;
            running <= 1'b0;
            done    <= 1'b1;
          end
        end
      endcase
    end
  end

  // Output sample register
  always_ff @(posedge S_AXI_ACLK) begin
    out_q <= rd_data;
  end

  // Lost pattern writes
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN || clear_stb) begin
      overflow  <= 1'b0;
      dbg_error <= '0;
    end else if (overflow_event) begin
      overflow  <= 1'b1;
      dbg_error <= dbg_error + 1'b1;
    end
  end

  always_comb begin
    status                = '0;
    status[stat_running]  = running;
    status[stat_done]     = done;
    status[stat_overflow] = overflow;
  end

  // Defaults when nothing plays
  assign output_signals = show_v ? out_q : write_defaults;
  // Input captured in the cycle its sample is shown
  assign cap_push = show_v;
  assign cap_data = input_signals;
  assign rd_addr  = addr_q;
  assign wave_ptr = addr_q;

endmodule

/* source/apg_axi_top.sv */
`timescale 1ns/100ps

module apg_axi_top import axi_lite_pkg::*, apg_reg_pkg::*; #(
  parameter int num_sig  = 14,
  parameter int num_samp = 128
) (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic [axi_addr_width-1:0] S_AXI_AWADDR,
  input  logic [2:0]                S_AXI_AWPROT,
  input  logic                      S_AXI_AWVALID,
  output logic                      S_AXI_AWREADY,
  input  logic [axi_data_width-1:0] S_AXI_WDATA,
  input  logic [axi_strb_width-1:0] S_AXI_WSTRB,
  input  logic                      S_AXI_WVALID,
  output logic                      S_AXI_WREADY,
  output axi_resp_t                 S_AXI_BRESP,
  output logic                      S_AXI_BVALID,
  input  logic                      S_AXI_BREADY,
  input  logic [axi_addr_width-1:0] S_AXI_ARADDR,
  input  logic [2:0]                S_AXI_ARPROT,
  input  logic                      S_AXI_ARVALID,
  output logic                      S_AXI_ARREADY,
  output logic [axi_data_width-1:0] S_AXI_RDATA,
  output axi_resp_t                 S_AXI_RRESP,
  output logic                      S_AXI_RVALID,
  input  logic                      S_AXI_RREADY,
  input  logic [num_sig-1:0]        input_signals,
  output logic [num_sig-1:0]        output_signals
);

  localparam int ptr_w = $clog2(num_samp);

  // Register strobes
  logic [axi_data_width-1:0] reg_wdata;
  logic [axi_strb_width-1:0] reg_wr_strb [reg_count];
  logic [reg_count-1:0]      reg_rd_stb;
  logic [axi_data_width-1:0] reg_rdata [reg_count];

  // Datapath
  logic               run_stb;
  logic               clear_stb;
  logic               pattern_push;
  logic [num_sig-1:0] pattern_data;
  logic               pattern_full;
  logic [ptr_w:0]     pattern_len;
  logic [ptr_w-1:0]   pattern_addr;
  logic [num_sig-1:0] pattern_rd;
  logic               capture_pop;
  logic               cap_push;
  logic [num_sig-1:0] cap_data;
  logic [num_sig-1:0] capture_data;
  logic [ptr_w:0]     capture_len;
  logic [ptr_w:0]     capture_rd_ptr;
  logic [31:0]        n_samples;
  logic [7:0]         control;
  logic [num_sig-1:0] write_defaults;
  logic [31:0]        sample_count;
  logic [ptr_w-1:0]   wave_ptr;
  logic [2:0]         status;
  logic [31:0]        dbg_error;

  axi4lite_slave slave0 (.*);

  apg_reg_bank #(.num_sig(num_sig), .num_samp(num_samp)) bank0 (
    .*,
    .pattern_len    (pattern_len),
    .capture_len    (capture_len)
  );

  // Pattern buffer, read by the sequencer
  sample_buffer #(.num_sig(num_sig), .num_samp(num_samp)) pattern_buf (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .clear    (clear_stb),
    .push     (pattern_push),
    .push_data(pattern_data),
    .pop      (1'b0),
    .rd_addr  (pattern_addr),
    .rd_data  (pattern_rd),
    .count    (pattern_len),
    .rd_ptr   (),
    .full     (pattern_full)
  );

  // Capture buffer, drained by read_channel reads
  sample_buffer #(.num_sig(num_sig), .num_samp(num_samp)) capture_buf (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .clear    (clear_stb),
    .push     (cap_push),
    .push_data(cap_data),
    .pop      (capture_pop),
    .rd_addr  (capture_rd_ptr[ptr_w-1:0]),
    .rd_data  (capture_data),
    .count    (capture_len),
    .rd_ptr   (capture_rd_ptr),
    .full     ()
  );

  pattern_sequencer #(.num_sig(num_sig), .num_samp(num_samp)) seq0 (
    .*,
    .rd_addr       (pattern_addr),
    .rd_data       (pattern_rd),
    .overflow_event(pattern_push & pattern_full)
  );

endmodule

/* sim/apg_tb.sv */
`timescale 1ns/100ps

module apg_tb import axi_lite_pkg::*, apg_reg_pkg::*; ();

  localparam int num_sig      = 14;
  localparam int num_samp     = 16;
  localparam int clk_period   = 40;
  localparam int first_push   = 5;
  localparam int oneshot_len  = 10;
  localparam int loop_len     = 5;
  localparam int loop_periods = 3;

  // Cycle budget per test, one bus access costs a few cycles
  localparam int axi_op_cycles = 6;
  localparam int t1_cycles     = 13 * axi_op_cycles;
  localparam int t2_cycles     = (num_samp + 3 + 5) * axi_op_cycles;
  localparam int t3_cycles     = 6 * axi_op_cycles + oneshot_len + 8;
  localparam int t4_cycles     = (2 * oneshot_len + 1) * axi_op_cycles;
  localparam int t5_cycles     = 4 * axi_op_cycles + loop_periods * loop_len + 8;
  localparam int t6_cycles     = 7 * axi_op_cycles + 4;
  localparam int run_cycles    = 4 + t1_cycles + t2_cycles + t3_cycles + t4_cycles +
                                 t5_cycles + t6_cycles;

  typedef logic [num_sig-1:0]        sample_t;
  typedef logic [axi_data_width-1:0] word_t;

  // Expected view of the generator
  typedef struct packed {
    logic [num_sig-1:0] sample;
    logic [num_sig-1:0] capture;
    logic [31:0]        buf_len;
    logic [31:0]        dbg_err;
    logic [31:0]        play_len;
    logic               overflow;
  } model_t;

  logic                      S_AXI_ACLK;
  logic                      S_AXI_ARESETN;
  logic [axi_addr_width-1:0] S_AXI_AWADDR;
  logic [2:0]                S_AXI_AWPROT;
  logic                      S_AXI_AWVALID;
  logic                      S_AXI_AWREADY;
  logic [axi_data_width-1:0] S_AXI_WDATA;
  logic [axi_strb_width-1:0] S_AXI_WSTRB;
  logic                      S_AXI_WVALID;
  logic                      S_AXI_WREADY;
  axi_resp_t                 S_AXI_BRESP;
  logic                      S_AXI_BVALID;
  logic                      S_AXI_BREADY;
  logic [axi_addr_width-1:0] S_AXI_ARADDR;
  logic [2:0]                S_AXI_ARPROT;
  logic                      S_AXI_ARVALID;
  logic                      S_AXI_ARREADY;
  logic [axi_data_width-1:0] S_AXI_RDATA;
  axi_resp_t                 S_AXI_RRESP;
  logic                      S_AXI_RVALID;
  logic                      S_AXI_RREADY;
  logic [num_sig-1:0]        input_signals;
  logic [num_sig-1:0]        output_signals;

  // Model state and compare control
  sample_t pushed [$];
  int      n_samp_model;
  sample_t dflt_model;
  int      cmp_count;
  logic    cmp_loop;
  logic    cmp_done;
  string   test_name;
  int      fail_count;
  event    run_accepted;

  apg_axi_top #(.num_sig(num_sig), .num_samp(num_samp)) dut0 (.*);

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #(clk_period / 2) S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // Loopback, inverted output fed back as the capture input
  initial begin : loopback
    input_signals = '0;
    forever begin
      @(posedge S_AXI_ACLK);
      #2;
      input_signals = ~output_signals;
    end
  end

  //////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////

  function automatic model_t model_pattern(input int idx);
    model_t m;
    int     stored;
    // Buffer keeps the first num_samp pushes, the rest are lost
    stored     = (pushed.size() > num_samp) ? num_samp : pushed.size();
    m          = '0;
    m.buf_len  = stored;
    m.dbg_err  = pushed.size() - stored;
    m.overflow = m.dbg_err != 0;
    // Zero or oversize length plays the whole buffer
    m.play_len = (n_samp_model == 0 || n_samp_model > stored) ? stored : n_samp_model;
    if (m.play_len != 0) begin
      m.sample  = pushed[idx % m.play_len];
      m.capture = ~m.sample;
    end
    return m;
  endfunction

  function automatic word_t status_word(input logic running, input logic done,
                                        input logic overflow);
    word_t w;
    w               = '0;
    w[stat_running]  = running;
    w[stat_done]     = done;
    w[stat_overflow] = overflow;
    return w;
  endfunction

  function automatic logic [axi_addr_width-1:0] reg_byte_addr(input reg_addr_t idx);
    return axi_addr_width'(idx) << 2;
  endfunction

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("** Error %s %s expected 0x%08h actual 0x%08h",
               test_name, what, expected, actual);
      fail_count++;
      abort_run();
    end
  endtask

  task automatic check_sample(input string what, input sample_t expected,
                              input sample_t actual);
    if (actual !== expected) begin
      $display("** Error %s %s expected 0x%04h actual 0x%04h",
               test_name, what, expected, actual);
      fail_count++;
      abort_run();
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_t expected,
                            input axi_resp_t actual);
    if (actual !== expected) begin
      $display("** Error %s %s expected %0d actual %0d",
               test_name, what, expected, actual);
      fail_count++;
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // AXI4-Lite bus tasks, entered 2 ns after an edge
  //////////////////////////////////////////////////

  task automatic axi_write(input reg_addr_t idx, input word_t data);
    S_AXI_AWADDR  = reg_byte_addr(idx);
    S_AXI_WDATA   = data;
    S_AXI_WSTRB   = '1;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
    // Address and data accepted in the same cycle
    @(posedge S_AXI_ACLK);
    while (!S_AXI_AWREADY) @(posedge S_AXI_ACLK);
    if (S_AXI_WREADY !== 1'b1) begin
      $display("WREADY did not rise together with AWREADY in test %s", test_name);
      abort_run();
    end
    if (idx == addr_run) begin
      -> run_accepted;
    end
    #2;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b1;
    @(posedge S_AXI_ACLK);
    while (!S_AXI_BVALID) @(posedge S_AXI_ACLK);
    // OKAY is the only response
    check_resp("BRESP", 2'b00, S_AXI_BRESP);
    #2;
    S_AXI_BREADY = 1'b0;
  endtask

  task automatic axi_read(input reg_addr_t idx, output word_t data);
    S_AXI_ARADDR  = reg_byte_addr(idx);
    S_AXI_ARVALID = 1'b1;
    @(posedge S_AXI_ACLK);
    while (!S_AXI_ARREADY) @(posedge S_AXI_ACLK);
    #2;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b1;
    @(posedge S_AXI_ACLK);
    while (!S_AXI_RVALID) @(posedge S_AXI_ACLK);
    data = S_AXI_RDATA;
    check_resp("RRESP", 2'b00, S_AXI_RRESP);
    #2;
    S_AXI_RREADY = 1'b0;
  endtask

  task automatic expect_reg(input reg_addr_t idx, input word_t expected, input string what);
    word_t data;
    axi_read(idx, data);
    check_word(what, expected, data);
  endtask

  // Playback compare, one shown sample per cycle
  initial begin : compare_output
    int     k;
    model_t m;
    forever begin
      @(run_accepted);
      // Sample 0 four cycles after the run handshake
      repeat (4) @(posedge S_AXI_ACLK);
      for (k = 0; k < cmp_count; k++) begin
        m = model_pattern(k);
        check_sample($sformatf("output sample %0d", k), m.sample, output_signals);
        @(posedge S_AXI_ACLK);
      end
      if (!cmp_loop) begin
        check_sample("output back at defaults", dflt_model, output_signals);
      end
      cmp_done = 1'b1;
    end
  end

  initial begin : watchdog
    #(2 * run_cycles * clk_period);
    $display("Watchdog expired, the tests did not complete in time");
    abort_run();
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main_seq
    word_t   rd;
    model_t  m;
    sample_t s;
    int      i;
    void'($urandom(32'h1c21f124));
    fail_count    = 0;
    n_samp_model  = 0;
    dflt_model    = '0;
    cmp_count     = 0;
    cmp_loop      = 1'b0;
    cmp_done      = 1'b0;
    test_name     = "reset";
    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWPROT  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARPROT  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b0;
    repeat (4) @(posedge S_AXI_ACLK);
    #2;
    S_AXI_ARESETN = 1'b1;

    // Every register reads zero after reset
    for (i = 0; i < reg_count; i++) begin
      expect_reg(reg_addr_t'(i), '0, $sformatf("register %0d", i));
    end
    check_sample("output after reset", '0, output_signals);

    // Fill the pattern buffer and run past its end
    test_name = "push";
    for (i = 0; i < num_samp + 3; i++) begin
      s = sample_t'($urandom());
      pushed.push_back(s);
      axi_write(addr_write_channel, word_t'(s));
      if (i == first_push - 1) begin
        m = model_pattern(0);
        expect_reg(addr_write_buffer_len, m.buf_len, "write_buffer_len partial");
      end
    end
    m = model_pattern(0);
    expect_reg(addr_write_channel, word_t'(pushed[$]), "write_channel last");
    expect_reg(addr_write_buffer_len, m.buf_len, "write_buffer_len full");
    expect_reg(addr_dbg_error, m.dbg_err, "dbg_error");
    expect_reg(addr_status, status_word(1'b0, 1'b0, m.overflow), "status");

    // One-shot playback
    test_name  = "oneshot";
    dflt_model = sample_t'($urandom());
    axi_write(addr_write_defaults, word_t'(dflt_model));
    n_samp_model = oneshot_len;
    axi_write(addr_n_samples, word_t'(oneshot_len));
    axi_write(addr_control, '0);
    m         = model_pattern(0);
    cmp_count = m.play_len;
    cmp_loop  = 1'b0;
    cmp_done  = 1'b0;
    axi_write(addr_run, word_t'(1));
    wait (cmp_done);
    @(posedge S_AXI_ACLK);
    #2;
    expect_reg(addr_sample_count, m.play_len, "sample_count");
    expect_reg(addr_status, status_word(1'b0, 1'b1, m.overflow), "status");

    // Captured loopback values, one per read
    test_name = "capture";
    for (i = 0; i < oneshot_len; i++) begin
      expect_reg(addr_next_read_sample, word_t'(i), $sformatf("next_read_sample %0d", i));
      axi_read(addr_read_channel, rd);
      m = model_pattern(i);
      check_sample($sformatf("read_channel %0d", i), m.capture, rd[num_sig-1:0]);
    end
    expect_reg(addr_next_read_sample, word_t'(oneshot_len), "next_read_sample end");

    // Continuous loop over a shorter length
    test_name    = "loop";
    n_samp_model = loop_len;
    axi_write(addr_n_samples, word_t'(loop_len));
    axi_write(addr_control, word_t'(1) << ctrl_loop);
    m         = model_pattern(0);
    cmp_count = loop_periods * m.play_len;
    cmp_loop  = 1'b1;
    cmp_done  = 1'b0;
    axi_write(addr_run, word_t'(1));
    wait (cmp_done);
    @(posedge S_AXI_ACLK);
    #2;
    expect_reg(addr_status, status_word(1'b1, 1'b0, m.overflow), "status running");

    // Clear stops the loop and empties both buffers
    test_name = "clear";
    axi_write(addr_clear, word_t'(1));
    pushed.delete();
    m = model_pattern(0);
    expect_reg(addr_write_buffer_len, m.buf_len, "write_buffer_len");
    expect_reg(addr_dbg_error, m.dbg_err, "dbg_error");
    expect_reg(addr_sample_count, '0, "sample_count");
    expect_reg(addr_next_read_sample, '0, "next_read_sample");
    expect_reg(addr_wave_ptr, '0, "wave_ptr");
    expect_reg(addr_status, status_word(1'b0, 1'b0, m.overflow), "status");
    check_sample("output after clear", dflt_model, output_signals);

    if (fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

/* list.f */
source/axi_lite_pkg.sv
source/apg_reg_pkg.sv
source/axi4lite_slave.sv
source/apg_reg_bank.sv
source/sample_buffer.sv
source/pattern_sequencer.sv
source/apg_axi_top.sv
sim/apg_tb.sv
